/* Bender.yml */
package:
  name: rv_ex

sources:
  - src/rv_ex_pkg.sv
  - src/rv_alu.sv
  - src/rv_div.sv
  - src/rv_wb_sel.sv
  - src/rv_ex_top.sv
  - target: simulation
    files:
      - dv/rv_ex_chk.sv
      - dv/rv_ex_tb.sv

/* dv/rv_ex_chk.sv */
// ====================
// bound assertions on issue, hold
// and writeback
// ====================

`timescale 1ns/1ps

module rv_ex_chk
    import rv_ex_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input logic      issue_i,
    input ex_req_t   req_i,
    input logic      hold_i,
    input wb_t       wb_i,
    input unit_res_t alu_res_i,
    input unit_res_t div_res_i
);

    logic div_issue;

    assign div_issue = issue_i && ((req_i.op & DIV_OP_MASK) == DIV_OP_MASK);

    no_issue_in_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(issue_i && hold_i))
        else $error("issue strobe seen while hold is high");

    one_unit_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(alu_res_i.valid && div_res_i.valid))
        else $error("ALU and divider results valid in the same cycle");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.we |-> (wb_i.waddr != '0))
        else $error("write enable raised for register x0");

    div_raises_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_issue |=> hold_i)
        else $error("hold not raised after a divide issue");

endmodule

/* dv/rv_ex_tb.sv */
// ====================
// execute stage testbench, table driven
// with a RISC-V reference model
// ====================

`timescale 1ns/1ps

module rv_ex_tb
    import rv_ex_pkg::*;
();

    typedef struct packed {
        ex_req_t req;
        xlen_t   exp;
        logic    exp_we;
    } tc_t;

    logic    clk;
    logic    rst_n_i;
    logic    issue_i;
    ex_req_t req_i;
    wb_t     wb_o;
    logic    hold_o;

    tc_t     dir_tab[$];   // directed edge cases
    tc_t     rnd_tab[$];
    ex_req_t burst[$];     // back-to-back ALU issues
    int      cycles;
    int      limit;

    rv_ex_top u_rv_ex_top (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .wb_o    (wb_o),
        .hold_o  (hold_o)
    );

    bind rv_ex_top rv_ex_chk u_chk (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .issue_i   (issue_i),
        .req_i     (req_i),
        .hold_i    (hold_o),
        .wb_i      (wb_o),
        .alu_res_i (alu_res),
        .div_res_i (div_res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic is_div_op(ex_op_t op);
        return op >= OP_DIV;
    endfunction

    // RV32I and RV32M semantics including divide by zero and overflow
    function automatic xlen_t ref_result(ex_req_t r);
        logic signed [31:0] a;
        logic signed [31:0] b;
        xlen_t              sq;
        xlen_t              sr;
        a  = r.rs1;
        b  = r.rs2;
        sq = '1;      // zero divisor quotient
        sr = r.rs1;   // zero divisor remainder
        if (r.rs2 != '0) begin
            if (r.rs1 == 32'h8000_0000 && r.rs2 == 32'hffff_ffff) begin
                sq = 32'h8000_0000;
                sr = '0;
            end else begin
                sq = a / b;
                sr = a % b;
            end
        end
        case (r.op)
            OP_ADD:  return r.rs1 + r.rs2;
            OP_SUB:  return r.rs1 - r.rs2;
            OP_SLL:  return r.rs1 << r.rs2[4:0];
            OP_SLT:  return (a < b) ? 32'd1 : 32'd0;
            OP_SLTU: return (r.rs1 < r.rs2) ? 32'd1 : 32'd0;
            OP_XOR:  return r.rs1 ^ r.rs2;
            OP_SRL:  return r.rs1 >> r.rs2[4:0];
            OP_SRA:  return a >>> r.rs2[4:0];
            OP_OR:   return r.rs1 | r.rs2;
            OP_AND:  return r.rs1 & r.rs2;
            OP_DIV:  return sq;
            OP_REM:  return sr;
            OP_DIVU: return (r.rs2 == '0) ? '1 : r.rs1 / r.rs2;
            OP_REMU: return (r.rs2 == '0) ? r.rs1 : r.rs1 % r.rs2;
            default: return '0;
        endcase
    endfunction

    task automatic check_wb(string name, wb_t exp, wb_t act);
        if (act.we !== exp.we ||
            (exp.we && (act.waddr !== exp.waddr || act.wdata !== exp.wdata))) begin
            $display("FAIL %s expected we=%b rd=%0d data=%h actual we=%b rd=%0d data=%h",
                     name, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
            $display("Some tests failed");
            $fatal(1, "writeback mismatch");
        end
    endtask

    task automatic check_hold(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s expected hold=%b actual hold=%b", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "hold level mismatch");
        end
    endtask

    task automatic add_entry(ex_op_t op, xlen_t rs1, xlen_t rs2, reg_addr_t rd, xlen_t exp);
        tc_t tc;
        tc.req.op  = op;
        tc.req.rs1 = rs1;
        tc.req.rs2 = rs2;
        tc.req.rd  = rd;
        tc.exp     = exp;
        tc.exp_we  = (rd != '0);  // x0 never written
        dir_tab.push_back(tc);
    endtask

    // starts on a falling edge and ends on the one after writeback
    task automatic run_entry(tc_t tc, string name);
        wb_t  exp_wb;
        int   lat;
        logic div_op;
        div_op       = is_div_op(tc.req.op);
        lat          = div_op ? DIV_LATENCY : ALU_LATENCY;
        exp_wb.we    = tc.exp_we;
        exp_wb.waddr = tc.req.rd;
        exp_wb.wdata = tc.exp;
        while (hold_o) @(negedge clk);
        issue_i = 1'b1;
        req_i   = tc.req;
        @(negedge clk);
        issue_i = 1'b0;
        repeat (lat) begin
            check_hold({name, " hold"}, div_op, hold_o);  // high only while dividing
            check_wb({name, " idle"}, '0, wb_o);          // write pulse lasts one cycle
            @(negedge clk);
        end
        check_hold({name, " hold at writeback"}, 1'b0, hold_o);
        check_wb(name, exp_wb, wb_o);
    endtask

    initial begin
        tc_t tc;
        wb_t exp_wb;
        int  k;
        int  j;
        void'($urandom(32'h7fc8_b477));
        cycles  = 0;
        rst_n_i = 1'b0;
        issue_i = 1'b0;
        req_i   = '0;

        add_entry(OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 5'd1,  32'h8000_0000);
        add_entry(OP_SUB,  32'h0000_0000, 32'h0000_0001, 5'd2,  32'hffff_ffff);
        add_entry(OP_SLL,  32'h0000_0001, 32'h0000_001f, 5'd3,  32'h8000_0000);
        add_entry(OP_SLL,  32'h1234_5678, 32'h0000_0020, 5'd4,  32'h1234_5678);
        add_entry(OP_SLT,  32'h8000_0000, 32'h0000_0001, 5'd5,  32'h0000_0001);
        add_entry(OP_SLTU, 32'h8000_0000, 32'h0000_0001, 5'd6,  32'h0000_0000);
        add_entry(OP_XOR,  32'hff00_ff00, 32'h0ff0_0ff0, 5'd7,  32'hf0f0_f0f0);
        add_entry(OP_SRL,  32'h8000_0000, 32'h0000_001f, 5'd8,  32'h0000_0001);
        add_entry(OP_SRA,  32'h8000_0000, 32'h0000_001f, 5'd9,  32'hffff_ffff);
        add_entry(OP_SRA,  32'h8765_4321, 32'h0000_0000, 5'd10, 32'h8765_4321);
        add_entry(OP_OR,   32'hf000_0000, 32'h0000_000f, 5'd11, 32'hf000_000f);
        add_entry(OP_AND,  32'hf0f0_f0f0, 32'hff00_ff00, 5'd12, 32'hf000_f000);
        add_entry(OP_DIV,  32'hffff_fff9, 32'h0000_0002, 5'd13, 32'hffff_fffd);
        add_entry(OP_DIVU, 32'hffff_fff9, 32'h0000_0002, 5'd14, 32'h7fff_fffc);
        add_entry(OP_REM,  32'hffff_fff9, 32'h0000_0002, 5'd15, 32'hffff_ffff);
        add_entry(OP_REMU, 32'hffff_fff9, 32'h0000_0002, 5'd16, 32'h0000_0001);
        add_entry(OP_DIV,  32'h0000_0014, 32'hffff_fffd, 5'd17, 32'hffff_fffa);
        add_entry(OP_REM,  32'h0000_0014, 32'hffff_fffd, 5'd18, 32'h0000_0002);
        add_entry(OP_DIV,  32'h0000_0005, 32'h0000_0000, 5'd19, 32'hffff_ffff);
        add_entry(OP_DIVU, 32'h0000_0005, 32'h0000_0000, 5'd20, 32'hffff_ffff);
        add_entry(OP_REM,  32'hffff_fff9, 32'h0000_0000, 5'd21, 32'hffff_fff9);
        add_entry(OP_REMU, 32'h0000_0005, 32'h0000_0000, 5'd22, 32'h0000_0005);
        add_entry(OP_DIV,  32'h8000_0000, 32'hffff_ffff, 5'd23, 32'h8000_0000);
        add_entry(OP_REM,  32'h8000_0000, 32'hffff_ffff, 5'd24, 32'h0000_0000);
        add_entry(OP_ADD,  32'h0000_0001, 32'h0000_0002, 5'd0,  32'h0000_0003);
        add_entry(OP_DIV,  32'h0000_0064, 32'h0000_0007, 5'd0,  32'h0000_000e);

        burst.push_back('{op: OP_ADD, rs1: 32'd10, rs2: 32'd20, rd: 5'd1});
        burst.push_back('{op: OP_SUB, rs1: 32'd5, rs2: 32'd9, rd: 5'd2});
        burst.push_back('{op: OP_XOR, rs1: 32'h00ff_00ff, rs2: 32'hffff_0000, rd: 5'd3});
        burst.push_back('{op: OP_SLL, rs1: 32'h0000_0003, rs2: 32'd4, rd: 5'd4});
        burst.push_back('{op: OP_SRA, rs1: 32'hf000_0000, rs2: 32'd8, rd: 5'd5});

        repeat (10) begin
            k          = $urandom_range(0, 13);
            tc.req.op  = ex_op_t'((k < 10) ? k : k + 2);  // skip unused codes
            tc.req.rs1 = $urandom();
            tc.req.rs2 = ($urandom_range(0, 3) == 0) ? xlen_t'($urandom_range(0, 2)) : $urandom();
            tc.req.rd  = reg_addr_t'($urandom_range(1, 31));
            tc.exp     = ref_result(tc.req);
            tc.exp_we  = 1'b1;
            rnd_tab.push_back(tc);
        end

        limit = (dir_tab.size() + burst.size() + rnd_tab.size()) * (DIV_LATENCY + 4) + 100;

        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_hold("after reset", 1'b0, hold_o);
        check_wb("after reset", '0, wb_o);

        foreach (dir_tab[i]) begin
            run_entry(dir_tab[i], $sformatf("directed %0d", i));
        end

        // result of issue j shows two falling edges later
        for (j = 0; j < burst.size() + 2; j++) begin
            if (j >= 2) begin
                exp_wb = '{we: 1'b1, waddr: burst[j-2].rd, wdata: ref_result(burst[j-2])};
                check_wb($sformatf("burst %0d", j - 2), exp_wb, wb_o);
            end
            if (j < burst.size()) begin
                issue_i = 1'b1;
                req_i   = burst[j];
            end else begin
                issue_i = 1'b0;
            end
            @(negedge clk);
        end

        foreach (rnd_tab[i]) begin
            run_entry(rnd_tab[i], $sformatf("random %0d", i));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* flist.f */
src/rv_ex_pkg.sv
src/rv_alu.sv
src/rv_div.sv
src/rv_wb_sel.sv
src/rv_ex_top.sv
dv/rv_ex_chk.sv
dv/rv_ex_tb.sv

/* src/rv_alu.sv */
// ====================
// single-cycle integer ALU, registered
// result for non-divide ops
// ====================

`timescale 1ns/1ps

module rv_alu
    import rv_ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      issue_i,
    input  ex_req_t   req_i,
    output unit_res_t res_o
);

    xlen_t      alu_result;
    logic       alu_hit;    // op belongs to this unit
    logic [4:0] shamt;

    assign shamt = req_i.rs2[4:0];  // only low five bits count

    always_comb begin
        alu_result = '0;
        alu_hit    = 1'b1;
        case (req_i.op)
            OP_ADD:  alu_result = req_i.rs1 + req_i.rs2;
            OP_SUB:  alu_result = req_i.rs1 - req_i.rs2;
            OP_SLL:  alu_result = req_i.rs1 << shamt;
            OP_SLT:  alu_result = {31'b0, $signed(req_i.rs1) < $signed(req_i.rs2)};
            OP_SLTU: alu_result = {31'b0, req_i.rs1 < req_i.rs2};
            OP_XOR:  alu_result = req_i.rs1 ^ req_i.rs2;
            OP_SRL:  alu_result = req_i.rs1 >> shamt;
            OP_SRA:  alu_result = $signed(req_i.rs1) >>> shamt;
            OP_OR:   alu_result = req_i.rs1 | req_i.rs2;
            OP_AND:  alu_result = req_i.rs1 & req_i.rs2;
            default: alu_hit = 1'b0;  // codes 10, 11 and divides
        endcase
        // divide codes always belong to the divider
        if ((req_i.op & DIV_OP_MASK) == DIV_OP_MASK) begin
            alu_hit = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= issue_i & alu_hit;
        end
        if (issue_i && alu_hit) begin  // payload only moves on a hit
            res_o.rd   <= req_i.rd;
            res_o.data <= alu_result;
        end
    end

endmodule

/* src/rv_div.sv */
// ====================
// iterative restoring divider for
// DIV, DIVU, REM and REMU
// ====================

`timescale 1ns/1ps

module rv_div
    import rv_ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      issue_i,
    input  ex_req_t   req_i,
    output unit_res_t res_o,
    output logic      busy_o
);

    localparam int unsigned CNT_W = $clog2(DIV_STEPS + 1);
    localparam logic [CNT_W-1:0] STEP_END = CNT_W'(DIV_STEPS);

    div_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;

    xlen_t     dvd_q;       // dividend, shifts into quotient
    xlen_t     dvs_q;       // divisor magnitude
    xlen_t     rem_q;       // partial remainder
    xlen_t     result_q;
    reg_addr_t rd_q;
    logic      neg_quo_q;
    logic      neg_rem_q;
    logic      zero_q;      // divisor was zero
    logic      is_rem_q;

    logic        div_start;
    logic        is_signed;
    xlen_t       a_mag;
    xlen_t       b_mag;
    logic [32:0] rem_sh;
    logic [32:0] diff;
    xlen_t       quo_fix;
    xlen_t       rem_fix;

    assign div_start = issue_i && ((req_i.op & DIV_OP_MASK) == DIV_OP_MASK);
    assign is_signed = ~req_i.op[0];

    // operand magnitudes
    assign a_mag = (is_signed && req_i.rs1[31]) ? -req_i.rs1 : req_i.rs1;
    assign b_mag = (is_signed && req_i.rs2[31]) ? -req_i.rs2 : req_i.rs2;

    // one restoring step
    assign rem_sh = {rem_q, dvd_q[31]};
    assign diff   = rem_sh - {1'b0, dvs_q};  // bit 32 set means borrow

    // sign fix-up; 0x8000_0000 / -1 wraps back to 0x8000_0000 on its own
    assign quo_fix = zero_q ? '1 : (neg_quo_q ? -dvd_q : dvd_q);
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (div_start) begin
                        state_q <= DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    if (cnt_q == STEP_END) begin
                        state_q <= DIV_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DIV_DONE: state_q <= DIV_IDLE;  // result shown for one cycle
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && div_start) begin
            dvd_q     <= a_mag;
            dvs_q     <= b_mag;
            rem_q     <= '0;
            rd_q      <= req_i.rd;
            zero_q    <= (req_i.rs2 == '0);
            neg_quo_q <= is_signed & (req_i.rs1[31] ^ req_i.rs2[31]);
            neg_rem_q <= is_signed & req_i.rs1[31];
            is_rem_q  <= req_i.op[1];
        end else if (state_q == DIV_RUN) begin
            if (cnt_q != STEP_END) begin
                dvd_q <= {dvd_q[30:0], ~diff[32]};
                rem_q <= diff[32] ? rem_sh[31:0] : diff[31:0];
            end else begin
                result_q <= is_rem_q ? rem_fix : quo_fix;
            end
        end
    end

    assign res_o  = '{valid: (state_q == DIV_DONE), rd: rd_q, data: result_q};
    assign busy_o = (state_q != DIV_IDLE);

endmodule

/* src/rv_ex_pkg.sv */
// ====================
// execute stage shared types, op codes
// and divider constants
// ====================

package rv_ex_pkg;

    typedef logic [31:0] xlen_t;      // register data word
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [3:0]  ex_op_t;

    // integer ALU ops
    localparam ex_op_t OP_ADD  = 4'd0;
    localparam ex_op_t OP_SUB  = 4'd1;
    localparam ex_op_t OP_SLL  = 4'd2;
    localparam ex_op_t OP_SLT  = 4'd3;
    localparam ex_op_t OP_SLTU = 4'd4;
    localparam ex_op_t OP_XOR  = 4'd5;
    localparam ex_op_t OP_SRL  = 4'd6;
    localparam ex_op_t OP_SRA  = 4'd7;
    localparam ex_op_t OP_OR   = 4'd8;
    localparam ex_op_t OP_AND  = 4'd9;

    // divide ops, bit 0 unsigned, bit 1 remainder
    localparam ex_op_t OP_DIV  = 4'd12;
    localparam ex_op_t OP_DIVU = 4'd13;
    localparam ex_op_t OP_REM  = 4'd14;
    localparam ex_op_t OP_REMU = 4'd15;

    localparam ex_op_t DIV_OP_MASK = 4'b1100;  // both top bits set means divide

    localparam int unsigned DIV_STEPS   = 32;
    localparam int unsigned ALU_LATENCY = 1;
    localparam int unsigned DIV_LATENCY = 34;

    typedef struct packed {
        ex_op_t    op;
        xlen_t     rs1;
        xlen_t     rs2;
        reg_addr_t rd;
    } ex_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } wb_t;

    // result from either unit towards the writeback selector
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } unit_res_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

/* src/rv_ex_top.sv */
// ====================
// execute stage top, ALU and divider
// side by side with writeback merge
// ====================

`timescale 1ns/1ps

module rv_ex_top
    import rv_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    issue_i,
    input  ex_req_t req_i,
    output wb_t     wb_o,
    output logic    hold_o
);

    unit_res_t alu_res;
    unit_res_t div_res;

    rv_alu u_alu (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .res_o   (alu_res)
    );

    // busy level doubles as the stage hold flag
    rv_div u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .res_o   (div_res),
        .busy_o  (hold_o)
    );

    rv_wb_sel u_wb_sel (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .alu_res_i (alu_res),
        .div_res_i (div_res),
        .wb_o      (wb_o)
    );

endmodule

/* src/rv_wb_sel.sv */
// ====================
// writeback selector, merges ALU and
// divider results into one write port
// ====================

`timescale 1ns/1ps

module rv_wb_sel
    import rv_ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  unit_res_t alu_res_i,
    input  unit_res_t div_res_i,
    output wb_t       wb_o
);

    unit_res_t pick;
    logic      wr_en;

    // divider wins if both ever show up
    assign pick = div_res_i.valid ? div_res_i : alu_res_i;

    // x0 is hardwired, never written
    assign wr_en = pick.valid && (pick.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o.we <= wr_en;  // one-cycle pulse per result
        end
    end

    // address and data keep their last value between writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_o.waddr <= pick.rd;
            wb_o.wdata <= pick.data;
        end
    end

endmodule
